// ==== design/decodePkg.sv ====
package decodePkg;

// ===========================================================================
// Word widths and sizes
// ===========================================================================

	// One instruction word as it is stored in the ROM
	typedef logic [31:0] instrWord_t;

	// Word address into the instruction ROM
	typedef logic [3:0] addr_t;

	// Architectural register number, r0 reads as zero
	typedef logic [4:0] regNum_t;

	// Immediate after sign extension to the full data width
	typedef logic [31:0] imm_t;

	// Number of words held by the instruction ROM
	localparam int romDepth = 16;

// ===========================================================================
// Instruction format
// ===========================================================================

	typedef logic [5:0] opcode_t;

	// Opcodes of the reduced instruction set
	// Anything not listed here decodes as a break
	localparam opcode_t OP_NOP = 6'd0;
	localparam opcode_t OP_ADD = 6'd1;
	localparam opcode_t OP_ADDI = 6'd2;
	localparam opcode_t OP_AND = 6'd3;
	localparam opcode_t OP_LOAD = 6'd8;
	localparam opcode_t OP_STORE = 6'd9;
	localparam opcode_t OP_BEQ = 6'd16;
	localparam opcode_t OP_BRK = 6'd63;

	// Bit positions of the fields inside an instruction word
	// The immediate overlaps Rb, so a format uses one or the other as a source
	localparam int opcHi = 31;
	localparam int opcLo = 26;
	localparam int rtHi = 25;
	localparam int rtLo = 21;
	localparam int raHi = 20;
	localparam int raLo = 16;
	localparam int rbHi = 15;
	localparam int rbLo = 11;
	localparam int immHi = 15;
	localparam int immLo = 0;

// ===========================================================================
// Decoder output and arbiter state
// ===========================================================================

	// Decoded form of one instruction as handed to the host
	typedef struct packed {
		logic v;
		opcode_t opc;
		regNum_t Rt;
		regNum_t Ra;
		regNum_t Rb;
		// Register field is actually read or written by this instruction
		logic Rtv;
		logic Rav;
		logic Rbv;
		// Source register is r0
		logic Raz;
		logic Rbz;
		logic hasImm;
		imm_t imm;
		// Instruction class flags
		logic alu;
		logic load;
		logic store;
		logic mem;
		logic branch;
		logic nop;
		logic brk;
	} decodeBus_t;

	// Arbiter states, a busy state per lane holds the grant for a whole cycle
	typedef enum logic [1:0] {IDLE, BUSY0, BUSY1, RELEASE} arbState_t;

endpackage

// ==== design/memBusIf.sv ====
`timescale 1ns/10ps

// Four-phase instruction memory read bus
//
// The requester raises req with addr stable. The responder answers with ack
// and keeps data valid for as long as ack is high. The requester then drops
// req, the responder drops ack, and only after that may a new req rise
interface memBusIf import decodePkg::*; ();

	logic req;
	logic ack;
	addr_t addr;
	instrWord_t data;

	// Side that starts a read, a fetch unit or the arbiter toward the ROM
	modport requester (
		output req,
		output addr,
		input ack,
		input data
	);

	// Side that answers a read, the ROM or the arbiter toward a fetch unit
	modport responder (
		input req,
		input addr,
		output ack,
		output data
	);

endinterface

// ==== design/instrRom.sv ====
`timescale 1ns/10ps

// Instruction ROM with a four-phase read port
// The contents come from program.hex and cannot change at run time
module instrRom import decodePkg::*; (
	input logic clk,
	input logic rst,
	memBusIf.responder mem
);

	typedef enum logic {ROM_IDLE, ROM_ACK} romState_t;

	instrWord_t romArray [romDepth];
	romState_t state;
	instrWord_t dataQ;

	initial begin
		$readmemh("program.hex", romArray);
	end

	// Ack goes high one cycle after req is seen and stays up until req drops
	always_ff @(posedge clk) begin
		if (rst) begin
			state <= ROM_IDLE;
		end else begin
			case (state)
				ROM_IDLE: if (mem.req) state <= ROM_ACK;
				ROM_ACK: if (!mem.req) state <= ROM_IDLE;
				default: state <= ROM_IDLE;
			endcase
		end
	end

	// The word is read once, when the request is accepted, so data
	// cannot move while ack is high even if addr does
	always_ff @(posedge clk) begin
		if (state == ROM_IDLE && mem.req) begin
			dataQ <= romArray[mem.addr];
		end
	end

	assign mem.ack = (state == ROM_ACK);
	assign mem.data = dataQ;

	// Every rising ack answers a request that was pending the cycle before
	assert property (@(posedge clk) disable iff (rst) $rose(mem.ack) |-> $past(mem.req));

endmodule

// ==== design/memArbiter.sv ====
`timescale 1ns/10ps

// Round-robin arbiter between the two fetch lanes and the shared ROM
// A lane keeps the ROM for a complete four-phase cycle, and one idle
// cycle separates two grants
module memArbiter import decodePkg::*; (
	input logic clk,
	input logic rst,
	memBusIf.responder lane0Bus,
	memBusIf.responder lane1Bus,
	memBusIf.requester romBus
);

	arbState_t state;
	arbState_t nextState;
	// Set when lane 1 had the last grant, so a tie goes to lane 0
	logic lastWinner;
	logic ackQ;
	logic ackFell;

	// End of the four-phase cycle on the ROM side
	assign ackFell = ackQ && !romBus.ack;

// ===========================================================================
// Grant state machine
// ===========================================================================

	always_comb begin
		nextState = state;
		case (state)
			IDLE: begin
				if (lane0Bus.req && lane1Bus.req) begin
					nextState = lastWinner ? BUSY0 : BUSY1;
				end else if (lane0Bus.req) begin
					nextState = BUSY0;
				end else if (lane1Bus.req) begin
					nextState = BUSY1;
				end
			end
			BUSY0, BUSY1: if (ackFell) nextState = RELEASE;
			RELEASE: nextState = IDLE;
			default: nextState = IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= IDLE;
			lastWinner <= 1'b1;
			ackQ <= 1'b0;
		end else begin
			state <= nextState;
			ackQ <= romBus.ack;
			if (state == IDLE && nextState == BUSY0) lastWinner <= 1'b0;
			if (state == IDLE && nextState == BUSY1) lastWinner <= 1'b1;
		end
	end

// ===========================================================================
// Bus steering
// ===========================================================================

	// Only the granted lane reaches the ROM, the other one just waits
	assign romBus.req = (state == BUSY0) ? lane0Bus.req :
		(state == BUSY1) ? lane1Bus.req : 1'b0;
	assign romBus.addr = (state == BUSY1) ? lane1Bus.addr : lane0Bus.addr;

	assign lane0Bus.ack = (state == BUSY0) && romBus.ack;
	assign lane1Bus.ack = (state == BUSY1) && romBus.ack;
	assign lane0Bus.data = (state == BUSY0) ? romBus.data : '0;
	assign lane1Bus.data = (state == BUSY1) ? romBus.data : '0;

	// At most one lane sees ack, and ack never passes straight from one
	// lane to the other without a low cycle in between
	assert property (@(posedge clk) disable iff (rst)
		$onehot0({lane0Bus.ack, lane1Bus.ack}) &&
		!(lane0Bus.ack && $past(lane1Bus.ack)) &&
		!(lane1Bus.ack && $past(lane0Bus.ack)));

endmodule

// ==== design/fetchUnit.sv ====
`timescale 1ns/10ps

// Fetch controller for one lane
// Turns a host fetch request into one ROM read and starts the decoder
module fetchUnit import decodePkg::*; (
	input logic clk,
	input logic rst,
	input logic fetchReq,
	input addr_t pc,
	output logic fetchAck,
	memBusIf.requester mem,
	output instrWord_t instr,
	output logic decEn
);

	// Read on the bus, wait for ack to fall, let the decoder settle, report
	typedef enum logic [2:0] {F_IDLE, F_READ, F_ACKLOW, F_SETTLE, F_DONE} fetchState_t;

	fetchState_t state;
	addr_t pcQ;

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= F_IDLE;
			decEn <= 1'b0;
		end else begin
			// Decoder enable is a single-cycle pulse
			decEn <= 1'b0;
			case (state)
				F_IDLE: if (fetchReq) state <= F_READ;
				F_READ: begin
					if (mem.ack) begin
						decEn <= 1'b1;
						state <= F_ACKLOW;
					end
				end
				F_ACKLOW: if (!mem.ack) state <= F_SETTLE;
				// Registered decode is in place by now
				F_SETTLE: state <= F_DONE;
				// Everything stays put while the host keeps its request up
				F_DONE: if (!fetchReq) state <= F_IDLE;
				default: state <= F_IDLE;
			endcase
		end
	end

	// The address is taken with the host request and the word with the bus ack
	always_ff @(posedge clk) begin
		if (state == F_IDLE && fetchReq) pcQ <= pc;
		if (state == F_READ && mem.ack) instr <= mem.data;
	end

	assign mem.req = (state == F_READ);
	assign mem.addr = pcQ;
	assign fetchAck = (state == F_DONE);

	// The host keeps its request up until it has seen the ack
	assert property (@(posedge clk) disable iff (rst) $fell(fetchReq) |-> fetchAck);

endmodule

// ==== design/instrDecoder.sv ====
`timescale 1ns/10ps

// Registered instruction decoder
// Splits a word into register fields, immediate and class flags, and
// loads the result into dbo one cycle after en
module instrDecoder import decodePkg::*; (
	input logic clk,
	input logic rst,
	input logic en,
	input instrWord_t instr,
	output decodeBus_t dbo
);

	localparam int immBits = immHi - immLo + 1;

	opcode_t opc;
	decodeBus_t db;

	assign opc = instr[opcHi:opcLo];

// ===========================================================================
// Field extraction and class decode
// ===========================================================================

	always_comb begin
		db = '0;
		db.v = 1'b1;
		db.opc = opc;
		// Register fields are passed on as they are, the valid bits tell
		// which of them mean anything
		db.Rt = instr[rtHi:rtLo];
		db.Ra = instr[raHi:raLo];
		db.Rb = instr[rbHi:rbLo];
		db.Raz = (db.Ra == '0);
		db.Rbz = (db.Rb == '0);

		case (opc)
			OP_NOP: db.nop = 1'b1;
			OP_ADD, OP_AND: db.alu = 1'b1;
			OP_ADDI: begin
				db.alu = 1'b1;
				db.hasImm = 1'b1;
			end
			OP_LOAD: begin
				db.load = 1'b1;
				db.hasImm = 1'b1;
			end
			OP_STORE: begin
				db.store = 1'b1;
				db.hasImm = 1'b1;
			end
			OP_BEQ: begin
				db.branch = 1'b1;
				db.hasImm = 1'b1;
			end
			OP_BRK: db.brk = 1'b1;
			// Undefined opcodes trap like a break
			default: db.brk = 1'b1;
		endcase

		db.mem = db.load || db.store;

		// Only alu operations and loads write a result register
		db.Rtv = db.alu || db.load;
		db.Rav = !(db.nop || db.brk);
		// Rb is a source for reg-reg alu ops. Store reads the data to write
		// from it and beq the value to compare, even with an immediate
		db.Rbv = (db.alu && !db.hasImm) || db.store || db.branch;

		// The immediate reads as zero when the format has none
		if (db.hasImm) begin
			db.imm = {{($bits(imm_t) - immBits){instr[immHi]}}, instr[immHi:immLo]};
		end
	end

// ===========================================================================
// Output register
// ===========================================================================

	// After reset the output shows an invalid nop, so a host sampling early
	// sees nothing to execute
	always_ff @(posedge clk) begin
		if (rst) begin
			dbo <= '0;
			dbo.nop <= 1'b1;
		end else if (en) begin
			dbo <= db;
		end
	end

endmodule

// ==== design/decodeCluster.sv ====
`timescale 1ns/10ps

// Two-lane instruction decode cluster
// Each lane has its own fetch unit and decoder, both lanes share the ROM
// through a round-robin arbiter
module decodeCluster import decodePkg::*; (
	input logic clk,
	input logic rst,
	input logic fetchReq0,
	input logic fetchReq1,
	input addr_t pc0,
	input addr_t pc1,
	output logic fetchAck0,
	output logic fetchAck1,
	output decodeBus_t dec0,
	output decodeBus_t dec1
);

	// Lane buses run from a fetch unit to the arbiter, romBus from the
	// arbiter to the ROM
	memBusIf lane0Bus ();
	memBusIf lane1Bus ();
	memBusIf romBus ();

	instrWord_t instr0;
	instrWord_t instr1;
	logic decEn0;
	logic decEn1;

// ===========================================================================
// Lane 0
// ===========================================================================

	fetchUnit fetch0 (
		.clk(clk),
		.rst(rst),
		.fetchReq(fetchReq0),
		.pc(pc0),
		.fetchAck(fetchAck0),
		.mem(lane0Bus.requester),
		.instr(instr0),
		.decEn(decEn0)
	);

	instrDecoder dec0Unit (.clk(clk), .rst(rst), .en(decEn0), .instr(instr0), .dbo(dec0));

// ===========================================================================
// Lane 1
// ===========================================================================

	fetchUnit fetch1 (
		.clk(clk),
		.rst(rst),
		.fetchReq(fetchReq1),
		.pc(pc1),
		.fetchAck(fetchAck1),
		.mem(lane1Bus.requester),
		.instr(instr1),
		.decEn(decEn1)
	);

	instrDecoder dec1Unit (.clk(clk), .rst(rst), .en(decEn1), .instr(instr1), .dbo(dec1));

	// Shared instruction memory
	memArbiter arb0 (
		.clk(clk),
		.rst(rst),
		.lane0Bus(lane0Bus.responder),
		.lane1Bus(lane1Bus.responder),
		.romBus(romBus.requester)
	);

	instrRom rom0 (.clk(clk), .rst(rst), .mem(romBus.responder));

endmodule

// ==== tb/clockGen.sv ====
`timescale 1ns/10ps

// Free-running clock and a synchronous reset pulse for the testbench
module clockGen (
	output logic clk,
	output logic rst
);

	localparam int halfPeriod = 5;
	localparam int resetCycles = 4;

	initial begin
		clk = 1'b0;
		forever #halfPeriod clk = ~clk;
	end

	// Reset covers the first rising edges and is released between edges
	initial begin
		rst = 1'b1;
		repeat (resetCycles) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
	end

endmodule

// ==== tb/decodeClusterTb.sv ====
`timescale 1ns/10ps

// Table-driven testbench for the two-lane decode cluster
module decodeClusterTb import decodePkg::*; ();

	// Expected decode of one ROM word and the lane that fetches it
	typedef struct {
		string name;
		int lane;
		addr_t pc;
		opcode_t opc;
		regNum_t Rt;
		regNum_t Ra;
		regNum_t Rb;
		imm_t imm;
		// alu, load, store, mem, branch, nop, brk
		logic [6:0] cls;
		// Rtv, Rav, Rbv, Raz, Rbz, hasImm
		logic [5:0] vld;
	} entry_t;

	localparam int numPairs = 5;

	logic clk;
	logic rst;
	logic fetchReq0;
	logic fetchReq1;
	addr_t pc0;
	addr_t pc1;
	logic fetchAck0;
	logic fetchAck1;
	decodeBus_t dec0;
	decodeBus_t dec1;

	entry_t stim [$];
	int errors = 0;
	int checks = 0;
	int cycles = 0;
	int cycleLimit;

	clockGen clkGen0 (.clk(clk), .rst(rst));

	decodeCluster dut0 (
		.clk(clk),
		.rst(rst),
		.fetchReq0(fetchReq0),
		.fetchReq1(fetchReq1),
		.pc0(pc0),
		.pc1(pc1),
		.fetchAck0(fetchAck0),
		.fetchAck1(fetchAck1),
		.dec0(dec0),
		.dec1(dec1)
	);

// ============================================================================
// Helpers
// ============================================================================

	function automatic void addEntry(string name, int lane, addr_t pc, opcode_t opc,
		regNum_t rt, regNum_t ra, regNum_t rb, imm_t imm, logic [6:0] cls, logic [5:0] vld);
		entry_t e;
		e = '{name, lane, pc, opc, rt, ra, rb, imm, cls, vld};
		stim.push_back(e);
	endfunction

	function automatic logic ackOf(int lane);
		return (lane == 0) ? fetchAck0 : fetchAck1;
	endfunction

	function automatic decodeBus_t decOf(int lane);
		return (lane == 0) ? dec0 : dec1;
	endfunction

	task automatic checkField(string test, string field, logic [31:0] exp, logic [31:0] act);
		checks++;
		assert (act === exp) else begin
			errors++;
			$display("FAIL %s %s: expected %0h, actual %0h", test, field, exp, act);
		end
	endtask

	// Flags are compared as groups in the same bit order as the table
	task automatic checkDecode(string test, entry_t e, decodeBus_t d);
		checkField(test, "v", 32'(1'b1), 32'(d.v));
		checkField(test, "opc", 32'(e.opc), 32'(d.opc));
		checkField(test, "Rt", 32'(e.Rt), 32'(d.Rt));
		checkField(test, "Ra", 32'(e.Ra), 32'(d.Ra));
		checkField(test, "Rb", 32'(e.Rb), 32'(d.Rb));
		checkField(test, "imm", e.imm, d.imm);
		checkField(test, "class", 32'(e.cls),
			32'({d.alu, d.load, d.store, d.mem, d.branch, d.nop, d.brk}));
		checkField(test, "valid", 32'(e.vld),
			32'({d.Rtv, d.Rav, d.Rbv, d.Raz, d.Rbz, d.hasImm}));
	endtask

	// One four-phase host fetch that keeps the request up for hold extra cycles
	task automatic runFetch(int lane, int idx, int hold);
		string test;
		decodeBus_t snapshot;
		test = $sformatf("lane%0d %s", lane, stim[idx].name);
		@(negedge clk);
		if (lane == 0) begin
			pc0 = stim[idx].pc;
			fetchReq0 = 1'b1;
		end else begin
			pc1 = stim[idx].pc;
			fetchReq1 = 1'b1;
		end
		do @(negedge clk); while (!ackOf(lane));
		checkDecode(test, stim[idx], decOf(lane));
		snapshot = decOf(lane);
		repeat (hold) begin
			@(negedge clk);
			checks++;
			assert (decOf(lane) === snapshot) else begin
				errors++;
				$display("FAIL %s held dec: expected %h, actual %h", test, snapshot, decOf(lane));
			end
			assert (ackOf(lane)) else begin
				errors++;
				$display("Lane %0d dropped fetchAck while the host still held fetchReq", lane);
			end
		end
		if (lane == 0) fetchReq0 = 1'b0;
		else fetchReq1 = 1'b0;
		do @(negedge clk); while (ackOf(lane));
	endtask

// ============================================================================
// Stimulus
// ============================================================================

	initial begin
		int a;
		int b;
		fetchReq0 = 1'b0;
		fetchReq1 = 1'b0;
		pc0 = '0;
		pc1 = '0;
		void'($urandom(5));

		// Expected fields follow the word layout of program.hex
		addEntry("add", 0, 4'd0, OP_ADD, 5'd3, 5'd1, 5'd2, 32'h0, 7'b1000000, 6'b111000);
		addEntry("and_r0", 1, 4'd1, OP_AND, 5'd5, 5'd0, 5'd4, 32'h0, 7'b1000000, 6'b111100);
		addEntry("addi_neg", 0, 4'd2, OP_ADDI, 5'd7, 5'd6, 5'd31, 32'hFFFFFFFC, 7'b1000000, 6'b110001);
		addEntry("load", 1, 4'd3, OP_LOAD, 5'd8, 5'd2, 5'd0, 32'h10, 7'b0101000, 6'b110011);
		addEntry("store", 0, 4'd4, OP_STORE, 5'd0, 5'd3, 5'd4, 32'h2008, 7'b0011000, 6'b011001);
		addEntry("beq", 1, 4'd5, OP_BEQ, 5'd0, 5'd1, 5'd2, 32'h1004, 7'b0000100, 6'b011001);
		addEntry("nop", 0, 4'd6, OP_NOP, 5'd0, 5'd0, 5'd0, 32'h0, 7'b0000010, 6'b000110);
		addEntry("undef5", 1, 4'd7, 6'd5, 5'd1, 5'd0, 5'd0, 32'h0, 7'b0000001, 6'b000110);
		addEntry("brk", 0, 4'd8, OP_BRK, 5'd0, 5'd0, 5'd0, 32'h0, 7'b0000001, 6'b000110);
		addEntry("add_rb0", 1, 4'd9, OP_ADD, 5'd10, 5'd11, 5'd0, 32'h0, 7'b1000000, 6'b111010);
		addEntry("addi_pos", 0, 4'd10, OP_ADDI, 5'd1, 5'd2, 5'd15, 32'h7FFF, 7'b1000000, 6'b110001);
		addEntry("load_neg", 1, 4'd11, OP_LOAD, 5'd4, 5'd0, 5'd31, 32'hFFFFFFFF, 7'b0101000, 6'b110101);
		addEntry("and_high", 0, 4'd12, OP_AND, 5'd31, 5'd30, 5'd29, 32'h0, 7'b1000000, 6'b111000);
		addEntry("beq_2", 1, 4'd13, OP_BEQ, 5'd0, 5'd5, 5'd6, 32'h3010, 7'b0000100, 6'b011001);
		addEntry("store_neg", 0, 4'd14, OP_STORE, 5'd0, 5'd7, 5'd17, 32'hFFFF8804, 7'b0011000, 6'b011001);
		addEntry("undef42", 1, 4'd15, 6'd42, 5'd0, 5'd0, 5'd0, 32'h0, 7'b0000001, 6'b000110);

		// Single fetches, the contention pairs and the two back-pressure fetches
		cycleLimit = 40 * (stim.size() + 2 * numPairs + 2) + 20;

		do @(negedge clk); while (rst);
		checkField("reset", "dec0 v", 32'(1'b0), 32'(dec0.v));
		checkField("reset", "dec0 nop", 32'(1'b1), 32'(dec0.nop));
		checkField("reset", "dec1 v", 32'(1'b0), 32'(dec1.v));
		checkField("reset", "dec1 nop", 32'(1'b1), 32'(dec1.nop));
		checkField("reset", "fetchAck0", 32'(1'b0), 32'(fetchAck0));
		checkField("reset", "fetchAck1", 32'(1'b0), 32'(fetchAck1));

		foreach (stim[i]) runFetch(stim[i].lane, i, 0);

		// Both lanes request in the same cycle. Different words come first,
		// then the same word and then random pairings
		for (int p = 0; p < numPairs; p++) begin
			if (p == 0) begin
				a = 0;
				b = 4;
			end else if (p == 1) begin
				a = 2;
				b = 2;
			end else begin
				a = int'($urandom_range(stim.size() - 1));
				b = int'($urandom_range(stim.size() - 1));
			end
			fork
				runFetch(0, a, 0);
				runFetch(1, b, 0);
			join
		end

		// Lane 0 is held by its host while lane 1 completes a fetch
		fork
			runFetch(0, 12, 10);
			begin
				do @(negedge clk); while (!fetchAck0);
				runFetch(1, 7, 0);
				assert (fetchAck0) else begin
					errors++;
					$display("Lane 1 did not complete its fetch while lane 0 was held");
				end
			end
		join

		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("Regression passed");
		end else begin
			$display("Regression failed");
		end
		$finish;
	end

	// Watchdog for a handshake that never completes
	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= cycleLimit) begin
			$display("Timeout after %0d cycles, a fetch handshake never completed", cycles);
			$display("Checks: %0d, errors: %0d", checks, errors + 1);
			$display("Regression failed");
			$finish;
		end
	end

endmodule

// ==== program.hex ====
// ROM image, one 32-bit instruction word in hex per line, addresses 0 to 15
// Fields: opcode [31:26], Rt [25:21], Ra [20:16], Rb [15:11], immediate [15:0]
04611000 // add r3, r1, r2
0CA02000 // and r5, r0, r4
08E6FFFC // addi r7, r6, -4
21020010 // load r8, 16(r2)
24032008 // store r4, 0x2008(r3)
40011004 // beq r1, r2, 0x1004
00000000 // nop
14200000 // undefined opcode 5
FC000000 // brk
054B0000 // add r10, r11, r0
08227FFF // addi r1, r2, 0x7fff
2080FFFF // load r4, -1(r0)
0FFEE800 // and r31, r30, r29
40053010 // beq r5, r6, 0x3010
24078804 // store r17, -0x77fc(r7)
A8000000 // undefined opcode 42

// ==== all.f ====
design/decodePkg.sv
design/memBusIf.sv
design/instrRom.sv
design/memArbiter.sv
design/fetchUnit.sv
design/instrDecoder.sv
design/decodeCluster.sv
tb/clockGen.sv
tb/decodeClusterTb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the decode cluster testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -f all.f --top-module decodeClusterTb -o simDecode

./obj_dir/simDecode | tee sim.log

if grep -q "Regression failed" sim.log; then
	echo "Simulation reported a failure"
	exit 1
fi

echo "Simulation finished without failure"
